// File: project.f
design/mdc_pkg.sv
design/hamming_decoder.sv
design/mdc_controller.sv
design/matrix_buffer.sv
design/minor_unit.sv
design/cofactor_accumulator.sv
design/mdc_top.sv
verif/mdc_tb.sv

// File: Makefile
# Verilator flow for the determinant calculator

VERILATOR  ?= verilator
TOP        ?= mdc_tb
FILE_LIST  ?= project.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary -Wno-fatal
PASS_MSG   ?= TEST OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

# The run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: verif/mdc_tb.sv
// ==============================
// Determinant calculator testbench with
// the case table, Hamming encoder, reference
// determinants, checker and watchdog
// ==============================
`timescale 1ns/100ps
`default_nettype none

module mdc_tb
    import mdc_pkg::*;
;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_CASES    = 10;
    localparam int WAIT_CYCLES  = 30;
    localparam int GAP_CYCLES   = 8;
    localparam int LAT_2X2      = 17;
    localparam int LAT_3X3      = 23;
    // Wait, pulse and gap of one matrix stay under 40 cycles
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_CASES * 40 + 50;

    // Error position 0 in a table row means no error
    typedef struct packed {
        logic [MODE_W-1:0]        mode;
        logic [15:0][ELEM_W-1:0]  elems;
        logic [4:0]               data_err;
        logic [3:0]               mode_err;
        logic                     valid;
    } tcase_t;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    logic [DATA_CODE_W-1:0] in_data;
    logic [MODE_CODE_W-1:0] in_mode;
    logic                   out_valid;
    result_t                out_data;

    tcase_t      cases [NUM_CASES];
    int          ref_m [4][4];
    logic [31:0] rng;
    int          check_count;

    mdc_top u_mdc_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_mode   (in_mode),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==============================
    // Reference model
    // ==============================
    // Data goes to non-power-of-two positions and parity to 1, 2, 4 and 8
    function automatic logic [DATA_CODE_W-1:0] encode(input logic [ELEM_W-1:0] value,
                                                      input int data_w);
        logic [DATA_CODE_W-1:0] code;
        int n;
        int k;
        int syn;
        n = data_w + 4;
        k = data_w - 1;
        code = '0;
        syn = 0;
        for (int p = 1; p <= n; p++) begin
            if ((p & (p - 1)) != 0) begin
                code[n-p] = value[k];
                k = k - 1;
            end
        end
        for (int p = 1; p <= n; p++) begin
            if (code[n-p]) begin
                syn = syn ^ p;
            end
        end
        // Parity bits cancel the data syndrome
        for (int i = 0; i < 4; i++) begin
            code[n-(1<<i)] = syn[i];
        end
        return code;
    endfunction

    function automatic logic [DATA_CODE_W-1:0] flip_bit(input logic [DATA_CODE_W-1:0] code,
                                                        input int code_w, input int pos);
        logic [DATA_CODE_W-1:0] res;
        res = code;
        res[code_w-pos] = ~code[code_w-pos];
        return res;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic longint det2_ref(input int r, input int c);
        return longint'(ref_m[r][c]) * ref_m[r+1][c+1]
             - longint'(ref_m[r][c+1]) * ref_m[r+1][c];
    endfunction

    // Cofactor expansion along the top row of the window
    function automatic longint det3_ref(input int r, input int c);
        longint a;
        longint b;
        longint d;
        a = longint'(ref_m[r+1][c+1]) * ref_m[r+2][c+2]
          - longint'(ref_m[r+1][c+2]) * ref_m[r+2][c+1];
        b = longint'(ref_m[r+1][c]) * ref_m[r+2][c+2]
          - longint'(ref_m[r+1][c+2]) * ref_m[r+2][c];
        d = longint'(ref_m[r+1][c]) * ref_m[r+2][c+1]
          - longint'(ref_m[r+1][c+1]) * ref_m[r+2][c];
        return ref_m[r][c] * a - ref_m[r][c+1] * b + ref_m[r][c+2] * d;
    endfunction

    // ==============================
    // Checking
    // ==============================
    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check(input string name, input result_t actual, input result_t expected);
        check_count = check_count + 1;
        if (actual !== expected) begin
            $display("** Error at %0t: %s = 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_result(input tcase_t tc);
        logic [DET2_W-1:0] exp2;
        logic [DET3_W-1:0] exp3;
        int msb;
        for (int k = 0; k < 16; k++) begin
            ref_m[k/4][k%4] = int'(elem_t'(tc.elems[k]));
        end
        if (tc.mode == MODE_2X2) begin
            for (int j = 0; j < 9; j++) begin
                msb  = OUT_W - 1 - DET2_W * j;
                exp2 = det2_ref(j / 3, j % 3);
                check($sformatf("out_data[%0d:%0d]", msb, msb - DET2_W + 1),
                      out_data[msb -: DET2_W], exp2);
            end
        end else begin
            check("out_data[206:204]", out_data[OUT_W-1 -: 3], '0);
            for (int j = 0; j < 4; j++) begin
                msb  = 4 * DET3_W - 1 - DET3_W * j;
                exp3 = det3_ref(j / 2, j % 2);
                check($sformatf("out_data[%0d:%0d]", msb, msb - DET3_W + 1),
                      out_data[msb -: DET3_W], exp3);
            end
        end
    endtask

    // ==============================
    // Case table
    // ==============================
    task automatic set_case(input int c, input logic [MODE_W-1:0] mode, input int data_err,
                            input int mode_err, input logic valid);
        cases[c].mode     = mode;
        cases[c].data_err = 5'(data_err);
        cases[c].mode_err = 4'(mode_err);
        cases[c].valid    = valid;
    endtask

    task automatic set_row(input int c, input int r, input int e0, input int e1,
                           input int e2, input int e3);
        cases[c].elems[4*r]   = ELEM_W'(e0);
        cases[c].elems[4*r+1] = ELEM_W'(e1);
        cases[c].elems[4*r+2] = ELEM_W'(e2);
        cases[c].elems[4*r+3] = ELEM_W'(e3);
    endtask

    task automatic random_rows(input int c, input int first, input int last);
        for (int r = first; r <= last; r++) begin
            for (int k = 0; k < 4; k++) begin
                rng = xorshift32(rng);
                cases[c].elems[4*r+k] = rng[ELEM_W-1:0];
            end
        end
    endtask

    task automatic build_table();
        rng = 32'hd9346c51;
        set_case(0, MODE_2X2, 0, 0, 1'b1);
        set_row(0, 0, 1, 2, 3, 4);
        set_row(0, 1, 5, -6, 7, 9);
        random_rows(0, 2, 3);
        // Full-scale elements
        set_case(1, MODE_2X2, 0, 0, 1'b1);
        set_row(1, 0, -1024, 1023, -1024, 1023);
        set_row(1, 1, -1024, -1024, 1023, -1024);
        set_row(1, 2, 1023, -1024, 1023, 1023);
        set_row(1, 3, 1023, 1023, -1024, -1024);
        set_case(2, MODE_3X3, 0, 0, 1'b1);
        random_rows(2, 0, 3);
        set_case(3, MODE_3X3, 0, 0, 1'b1);
        set_row(3, 0, -1024, 1023, -1024, 1023);
        set_row(3, 1, 1023, 1023, -1024, -1024);
        set_row(3, 2, -1024, -1024, -1024, 1023);
        set_row(3, 3, 1023, -1024, 1023, 1023);
        // Single-bit errors on every codeword
        set_case(4, MODE_2X2, 3, 5, 1'b1);
        random_rows(4, 0, 3);
        // Former 4x4 code
        set_case(5, 5'b10110, 0, 0, 1'b0);
        random_rows(5, 0, 3);
        set_case(6, MODE_3X3, 9, 1, 1'b1);
        random_rows(6, 0, 3);
        set_case(7, 5'b00000, 0, 7, 1'b0);
        random_rows(7, 0, 3);
        set_case(8, MODE_2X2, 15, 9, 1'b1);
        random_rows(8, 0, 3);
        set_case(9, MODE_3X3, 14, 2, 1'b1);
        set_row(9, 0, 1023, -1024, 512, -1);
        random_rows(9, 1, 2);
        set_row(9, 3, -1024, 0, 1023, 1023);
    endtask

    // ==============================
    // Stimulus
    // ==============================
    // Drive one matrix, then watch out_valid at the falling edge
    task automatic run_case(input int idx);
        tcase_t                 tc;
        logic [DATA_CODE_W-1:0] code;
        int                     n;
        int                     pos;
        logic                   seen;
        tc   = cases[idx];
        n    = 0;
        seen = 1'b0;
        while (!seen && n < WAIT_CYCLES) begin
            @(posedge clk);
            if (n < 16) begin
                code = encode(tc.elems[n], ELEM_W);
                if (tc.data_err != 0) begin
                    // Rotate the error position across the elements
                    pos  = (int'(tc.data_err) - 1 + n) % DATA_CODE_W + 1;
                    code = flip_bit(code, DATA_CODE_W, pos);
                end
                in_valid <= 1'b1;
                in_data  <= code;
                if (n == 0) begin
                    code = encode(ELEM_W'(tc.mode), MODE_W);
                    if (tc.mode_err != 0) begin
                        code = flip_bit(code, MODE_CODE_W, int'(tc.mode_err));
                    end
                    in_mode <= code[MODE_CODE_W-1:0];
                end
            end else begin
                in_valid <= 1'b0;
                in_data  <= '0;
            end
            @(negedge clk);
            if (out_valid) begin
                seen = 1'b1;
            end else begin
                n = n + 1;
            end
        end
        if (!seen && tc.valid) begin
            $display("Case %0d: out_valid did not rise within %0d cycles", idx, WAIT_CYCLES);
            abort_run();
        end
        if (seen && !tc.valid) begin
            $display("Case %0d: out_valid rose for the invalid mode %b", idx, tc.mode);
            abort_run();
        end
        if (seen) begin
            check("out_valid latency", n, (tc.mode == MODE_2X2) ? LAT_2X2 : LAT_3X3);
            check_result(tc);
            @(negedge clk);
            check("out_valid after pulse", out_valid, '0);
            check("out_data after pulse", out_data, '0);
        end else begin
            check("out_data after invalid mode", out_data, '0);
        end
        repeat (GAP_CYCLES) @(posedge clk);
    endtask

    initial begin
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_data     = '0;
        in_mode     = '0;
        check_count = 0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check("out_valid after reset", out_valid, '0);
        check("out_data after reset", out_data, '0);
        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(i);
        end
        $display("%0d cases, %0d checks", NUM_CASES, check_count);
        $display("TEST OK");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        abort_run();
    end

endmodule

`default_nettype wire

// File: design/mdc_top.sv
// ==============================
// Determinant calculator top,
// decoders and datapath wiring
// ==============================
`timescale 1ns/100ps
`default_nettype none

module mdc_top
    import mdc_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   in_valid,
    input  wire [DATA_CODE_W-1:0] in_data,
    input  wire [MODE_CODE_W-1:0] in_mode,
    output logic                  out_valid,
    output result_t               out_data
);

    logic [MODE_W-1:0] mode_dec;
    elem_t             data_dec;
    mdc_state_e        state;
    step_t             step;

    elem_t m00, m01, m02, m03;
    elem_t m10, m11, m12, m13;
    elem_t m20, m21, m22, m23;
    elem_t m30, m31, m32, m33;

    prod_t det2;
    prod_t mid_01;
    prod_t mid_02;
    prod_t mid_12;
    prod_t mid_13;
    prod_t mid_23;

    // ==============================
    // Input decoding
    // ==============================
    hamming_decoder #(.DATA_W(MODE_W)) u_mode_dec (
        .code (in_mode),
        .data (mode_dec)
    );

    hamming_decoder #(.DATA_W(ELEM_W)) u_data_dec (
        .code (in_data),
        .data (data_dec)
    );

    mdc_controller u_controller (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .mode      (mode_dec),
        .state     (state),
        .step      (step),
        .out_valid (out_valid)
    );

    // ==============================
    // Datapath
    // ==============================
    matrix_buffer u_matrix (
        .clk  (clk),
        .step (step),
        .data (data_dec),
        .m00  (m00), .m01 (m01), .m02 (m02), .m03 (m03),
        .m10  (m10), .m11 (m11), .m12 (m12), .m13 (m13),
        .m20  (m20), .m21 (m21), .m22 (m22), .m23 (m23),
        .m30  (m30), .m31 (m31), .m32 (m32), .m33 (m33)
    );

    minor_unit u_minor (
        .clk    (clk),
        .state  (state),
        .step   (step),
        .m00    (m00), .m01 (m01), .m02 (m02), .m03 (m03),
        .m10    (m10), .m11 (m11), .m12 (m12), .m13 (m13),
        .m20    (m20), .m21 (m21), .m22 (m22), .m23 (m23),
        .m30    (m30), .m31 (m31), .m32 (m32), .m33 (m33),
        .det2   (det2),
        .mid_01 (mid_01),
        .mid_02 (mid_02),
        .mid_12 (mid_12),
        .mid_13 (mid_13),
        .mid_23 (mid_23)
    );

    // Only rows 0 and 3 feed the cofactor terms
    cofactor_accumulator u_cofactor (
        .clk      (clk),
        .rst_n    (rst_n),
        .state    (state),
        .step     (step),
        .m00      (m00), .m01 (m01), .m02 (m02), .m03 (m03),
        .m30      (m30), .m31 (m31), .m32 (m32), .m33 (m33),
        .det2     (det2),
        .mid_01   (mid_01),
        .mid_02   (mid_02),
        .mid_12   (mid_12),
        .mid_13   (mid_13),
        .mid_23   (mid_23),
        .out_data (out_data)
    );

endmodule

`default_nettype wire

// File: design/cofactor_accumulator.sv
// ==============================
// Cofactor multiply-accumulate and
// the packed result register
// ==============================
`timescale 1ns/100ps
`default_nettype none

module cofactor_accumulator
    import mdc_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire mdc_state_e state,
    input  wire step_t      step,
    input  wire elem_t      m00, m01, m02, m03,
    input  wire elem_t      m30, m31, m32, m33,
    input  wire prod_t      det2,
    input  wire prod_t      mid_01,
    input  wire prod_t      mid_02,
    input  wire prod_t      mid_12,
    input  wire prod_t      mid_13,
    input  wire prod_t      mid_23,
    output result_t         out_data
);

    // Slot 0 of the 2x2 mode is the MSB field
    logic       det2_en;
    logic [3:0] det2_slot;
    int         det2_lsb;

    // 3x3 mode accumulator
    logic       acc_en;
    logic       acc_sub;
    logic [1:0] field;
    int         field_lsb;
    elem_t      coef;
    prod_t      minor;
    acc_t       product;
    acc_t       acc_in;
    acc_t       acc_out;

    always_comb begin
        det2_en   = 1'b1;
        det2_slot = '0;
        case (step)
            5'd6:    det2_slot = 4'd0;
            5'd7:    det2_slot = 4'd1;
            5'd8:    det2_slot = 4'd2;
            5'd10:   det2_slot = 4'd3;
            5'd11:   det2_slot = 4'd4;
            5'd12:   det2_slot = 4'd5;
            5'd14:   det2_slot = 4'd6;
            5'd15:   det2_slot = 4'd7;
            5'd16:   det2_slot = 4'd8;
            default: det2_en = 1'b0;
        endcase
    end

    assign det2_lsb = OUT_W - DET2_W * (int'(det2_slot) + 1);

    // ==============================
    // Cofactor step decode
    // ==============================
    // Three terms per determinant with signs +, -, +
    always_comb begin
        acc_en = 1'b1;
        field  = 2'd0;
        case (step) inside
            [5'd11:5'd13]: field = 2'd0;
            [5'd14:5'd16]: field = 2'd1;
            [5'd17:5'd19]: field = 2'd2;
            [5'd20:LAST_STEP_3X3]: field = 2'd3;
            default: acc_en = 1'b0;
        endcase
    end

    assign acc_sub = step inside {5'd12, 5'd15, 5'd18, 5'd21};

    // Rows 0-2 expand along row 0, rows 1-3 along row 3
    always_comb begin
        case (step)
            5'd11, 5'd15: coef = m02;
            5'd12, 5'd16: coef = m01;
            5'd13:        coef = m00;
            5'd14:        coef = m03;
            5'd17, 5'd21: coef = m32;
            5'd18, 5'd22: coef = m31;
            5'd19:        coef = m30;
            5'd20:        coef = m33;
            default:      coef = '0;
        endcase
    end

    always_comb begin
        case (step)
            5'd11, 5'd17:               minor = mid_01;
            5'd12, 5'd18:               minor = mid_02;
            5'd13, 5'd14, 5'd19, 5'd20: minor = mid_12;
            5'd15, 5'd21:               minor = mid_13;
            5'd16, 5'd22:               minor = mid_23;
            default:                    minor = '0;
        endcase
    end

    // Field 0 at bits 203:153 down to field 3 at bits 50:0
    assign field_lsb = DET3_W * (3 - int'(field));
    assign product   = coef * minor;
    assign acc_in    = acc_t'(out_data[field_lsb +: $bits(acc_t)]);
    assign acc_out   = acc_sub ? acc_in - product : acc_in + product;

    // ==============================
    // Result register
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_data <= '0;
        end else begin
            case (state)
                ST_M2X2: begin
                    if (det2_en) begin
                        out_data[det2_lsb +: DET2_W] <= DET2_W'(det2);
                    end
                end
                ST_M3X3: begin
                    if (acc_en) begin
                        out_data[field_lsb +: DET3_W] <= DET3_W'(acc_out);
                    end
                end
                default: out_data <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/minor_unit.sv
// ==============================
// 2x2 determinant datapath and the
// registered rows 1-2 minors
// ==============================
`timescale 1ns/100ps
`default_nettype none

module minor_unit
    import mdc_pkg::*;
(
    input  wire             clk,
    input  wire mdc_state_e state,
    input  wire step_t      step,
    input  wire elem_t      m00, m01, m02, m03,
    input  wire elem_t      m10, m11, m12, m13,
    input  wire elem_t      m20, m21, m22, m23,
    input  wire elem_t      m30, m31, m32, m33,
    output prod_t           det2,
    output prod_t           mid_01,
    output prod_t           mid_02,
    output prod_t           mid_12,
    output prod_t           mid_13,
    output prod_t           mid_23
);

    elem_t      mat [4][4];
    logic       sel_en;
    logic [1:0] row;
    logic [1:0] col_l;
    logic [1:0] col_r;
    elem_t      op_a;
    elem_t      op_b;
    elem_t      op_c;
    elem_t      op_d;
    prod_t      prod_ad;
    prod_t      prod_bc;

    assign mat = '{'{m00, m01, m02, m03},
                   '{m10, m11, m12, m13},
                   '{m20, m21, m22, m23},
                   '{m30, m31, m32, m33}};

    // ==============================
    // Submatrix select
    // ==============================
    // Top row index and the two columns of the 2x2 window
    always_comb begin
        sel_en = 1'b1;
        {row, col_l, col_r} = '0;
        case (state)
            ST_M2X2: begin
                case (step)
                    5'd6:    {row, col_l, col_r} = {2'd0, 2'd0, 2'd1};
                    5'd7:    {row, col_l, col_r} = {2'd0, 2'd1, 2'd2};
                    5'd8:    {row, col_l, col_r} = {2'd0, 2'd2, 2'd3};
                    5'd10:   {row, col_l, col_r} = {2'd1, 2'd0, 2'd1};
                    5'd11:   {row, col_l, col_r} = {2'd1, 2'd1, 2'd2};
                    5'd12:   {row, col_l, col_r} = {2'd1, 2'd2, 2'd3};
                    5'd14:   {row, col_l, col_r} = {2'd2, 2'd0, 2'd1};
                    5'd15:   {row, col_l, col_r} = {2'd2, 2'd1, 2'd2};
                    5'd16:   {row, col_l, col_r} = {2'd2, 2'd2, 2'd3};
                    default: sel_en = 1'b0;
                endcase
            end
            // Rows 1-2 over column pairs 01, 02, 12, 13, 23
            ST_M3X3: begin
                case (step)
                    MINOR_FIRST_STEP:        {row, col_l, col_r} = {2'd1, 2'd0, 2'd1};
                    MINOR_FIRST_STEP + 5'd1: {row, col_l, col_r} = {2'd1, 2'd0, 2'd2};
                    MINOR_FIRST_STEP + 5'd2: {row, col_l, col_r} = {2'd1, 2'd1, 2'd2};
                    MINOR_FIRST_STEP + 5'd3: {row, col_l, col_r} = {2'd1, 2'd1, 2'd3};
                    MINOR_FIRST_STEP + 5'd4: {row, col_l, col_r} = {2'd1, 2'd2, 2'd3};
                    default:                 sel_en = 1'b0;
                endcase
            end
            default: sel_en = 1'b0;
        endcase
    end

    always_comb begin
        if (sel_en) begin
            op_a = mat[row][col_l];
            op_b = mat[row][col_r];
            op_c = mat[row + 2'd1][col_l];
            op_d = mat[row + 2'd1][col_r];
        end else begin
            op_a = '0;
            op_b = '0;
            op_c = '0;
            op_d = '0;
        end
    end

    // a*d - b*c
    assign prod_ad = op_a * op_d;
    assign prod_bc = op_b * op_c;
    assign det2    = prod_ad - prod_bc;

    // ==============================
    // Minor registers
    // ==============================
    always_ff @(posedge clk) begin
        if (state == ST_M3X3) begin
            case (step)
                MINOR_FIRST_STEP:        mid_01 <= det2;
                MINOR_FIRST_STEP + 5'd1: mid_02 <= det2;
                MINOR_FIRST_STEP + 5'd2: mid_12 <= det2;
                MINOR_FIRST_STEP + 5'd3: mid_13 <= det2;
                MINOR_FIRST_STEP + 5'd4: mid_23 <= det2;
                default: ;
            endcase
        end else begin
            mid_01 <= '0;
            mid_02 <= '0;
            mid_12 <= '0;
            mid_13 <= '0;
            mid_23 <= '0;
        end
    end

endmodule

`default_nettype wire

// File: design/matrix_buffer.sv
// ==============================
// 4x4 element store, one element
// written per step, row-major
// ==============================
`timescale 1ns/100ps
`default_nettype none

module matrix_buffer
    import mdc_pkg::*;
(
    input  wire        clk,
    input  wire step_t step,
    input  wire elem_t data,
    output elem_t      m00, m01, m02, m03,
    output elem_t      m10, m11, m12, m13,
    output elem_t      m20, m21, m22, m23,
    output elem_t      m30, m31, m32, m33
);

    elem_t mem [16];

    // Steps 16 and up carry no element
    always_ff @(posedge clk) begin
        if (!step[STEP_W-1]) begin
            mem[step[3:0]] <= data;
        end
    end

    assign m00 = mem[0];
    assign m01 = mem[1];
    assign m02 = mem[2];
    assign m03 = mem[3];
    assign m10 = mem[4];
    assign m11 = mem[5];
    assign m12 = mem[6];
    assign m13 = mem[7];
    assign m20 = mem[8];
    assign m21 = mem[9];
    assign m22 = mem[10];
    assign m23 = mem[11];
    assign m30 = mem[12];
    assign m31 = mem[13];
    assign m32 = mem[14];
    assign m33 = mem[15];

endmodule

`default_nettype wire

// File: design/mdc_controller.sv
// ==============================
// Mode FSM, step counter and
// out_valid strobe
// ==============================
`timescale 1ns/100ps
`default_nettype none

module mdc_controller
    import mdc_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire              in_valid,
    input  wire [MODE_W-1:0] mode,
    output mdc_state_e       state,
    output step_t            step,
    output logic             out_valid
);

    mdc_state_e next_state;

    // ==============================
    // State register
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Mode only counts on the first valid cycle, where step is still 0
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (in_valid && step == '0) begin
                    case (mode)
                        MODE_2X2: next_state = ST_M2X2;
                        MODE_3X3: next_state = ST_M3X3;
                        default:  next_state = ST_IDLE;
                    endcase
                end
            end
            ST_M2X2: begin
                if (step == LAST_STEP_2X2) begin
                    next_state = ST_IDLE;
                end
            end
            ST_M3X3: begin
                if (step == LAST_STEP_3X3) begin
                    next_state = ST_IDLE;
                end
            end
            default: next_state = ST_IDLE;
        endcase
    end

    // ==============================
    // Step counter
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step <= '0;
        end else if (state == ST_IDLE && !in_valid) begin
            step <= '0;
        end else begin
            step <= step + 5'd1;
        end
    end

    // One-cycle pulse after the last step of a mode
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            case (state)
                ST_M2X2: out_valid <= (step == LAST_STEP_2X2);
                ST_M3X3: out_valid <= (step == LAST_STEP_3X3);
                default: out_valid <= 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/hamming_decoder.sv
// ==============================
// Single-error-correcting Hamming
// decoder, 4 parity bits
// ==============================
`timescale 1ns/100ps
`default_nettype none

module hamming_decoder #(
    parameter int  DATA_W = 11,
    localparam int CODE_W = DATA_W + 4
) (
    input  wire  [CODE_W-1:0] code,
    output logic [DATA_W-1:0] data
);

    logic [3:0]        syndrome;
    logic [CODE_W-1:0] fixed;

    // Position p counts from 1 at the MSB, so it sits at bit CODE_W-p
    always_comb begin
        syndrome = '0;
        for (int p = 1; p <= CODE_W; p++) begin
            if (code[CODE_W-p]) begin
                syndrome = syndrome ^ 4'(p);
            end
        end
    end

    // Flip the bit the syndrome points at
    always_comb begin
        fixed = code;
        if (syndrome != '0 && int'(syndrome) <= CODE_W) begin
            fixed[CODE_W-int'(syndrome)] = ~code[CODE_W-int'(syndrome)];
        end
    end

    // Data sits at the non-power-of-two positions, MSB first
    always_comb begin
        int k;
        k = DATA_W - 1;
        data = '0;
        for (int p = 3; p <= CODE_W; p++) begin
            if ((p & (p - 1)) != 0) begin
                data[k] = fixed[CODE_W-p];
                k = k - 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/mdc_pkg.sv
// ==============================
// Widths, element types, mode codes,
// step numbers and FSM states
// ==============================
`default_nettype none

package mdc_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int ELEM_W      = 11;
    localparam int MODE_W      = 5;
    localparam int DATA_CODE_W = 15;
    localparam int MODE_CODE_W = 9;
    localparam int STEP_W      = 5;
    localparam int DET2_W      = 23;
    localparam int DET3_W      = 51;
    localparam int OUT_W       = 207;

    typedef logic signed [ELEM_W-1:0]   elem_t;
    // Element product, also a full 2x2 determinant
    typedef logic signed [2*ELEM_W-1:0] prod_t;
    // Element times minor, and the running cofactor sum
    typedef logic signed [44:0]         acc_t;
    typedef logic [STEP_W-1:0]          step_t;
    typedef logic [OUT_W-1:0]           result_t;

    // Decoded mode codes
    localparam logic [MODE_W-1:0] MODE_2X2 = 5'b00100;
    localparam logic [MODE_W-1:0] MODE_3X3 = 5'b00110;

    // ==============================
    // Step numbers
    // ==============================
    localparam step_t LAST_STEP_2X2    = 5'd16;
    localparam step_t LAST_STEP_3X3    = 5'd22;
    localparam step_t MINOR_FIRST_STEP = 5'd10;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_M2X2,
        ST_M3X3
    } mdc_state_e;

endpackage

`default_nettype wire
